// File: flist.f
hdl/mem_sub_pkg.sv
hdl/data_ram.sv
hdl/debug_apb_master.sv
hdl/req_decode.sv
hdl/access_stage.sv
hdl/rsp_buffer.sv
hdl/mem_subsystem.sv
verification/mem_subsystem_chk.sv
verification/tb_mem_subsystem.sv

// File: hdl/access_stage.sv
/* Stage two: one held item, dispatched to the data RAM, the APB master or tohost */
`timescale 1ns/1ps
`default_nettype none

module access_stage (
  input  wire                            clk,
  input  wire                            reset_n,
  input  wire                            i_dec_valid,
  output logic                           o_dec_ready,
  input  wire mem_sub_pkg::op_e          i_dec_op,
  input  wire mem_sub_pkg::region_e      i_dec_region,
  input  wire [mem_sub_pkg::ADDR_W-1:0]  i_dec_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_dec_wdata,
  input  wire                            i_init_wen,
  input  wire [mem_sub_pkg::ADDR_W-1:0]  i_init_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_init_data,
  output logic                           o_acc_valid,
  input  wire                            i_acc_ready,
  output logic [mem_sub_pkg::DATA_W-1:0] o_acc_rdata,
  output logic                           o_acc_error,
  output logic [mem_sub_pkg::DATA_W-1:0] o_tohost,
  output logic [mem_sub_pkg::APB_AW-1:0] o_apb_paddr,
  output logic                           o_apb_psel,
  output logic                           o_apb_penable,
  output logic                           o_apb_pwrite,
  output logic [mem_sub_pkg::DATA_W-1:0] o_apb_pwdata,
  input  wire                            i_apb_pready,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_apb_prdata,
  input  wire                            i_apb_pslverr
);

  logic                           take;
  logic                           leave;
  logic                           dec_write;
  logic                           busy_q;
  mem_sub_pkg::op_e               op_q;
  mem_sub_pkg::region_e           region_q;
  logic [mem_sub_pkg::DATA_W-1:0] rdata_q;
  logic                           error_q;
  logic [mem_sub_pkg::DATA_W-1:0] ram_rd_data;
  logic                           apb_done;
  logic [mem_sub_pkg::DATA_W-1:0] apb_rdata;
  logic                           apb_error;

  assign o_dec_ready = !busy_q;
  assign take        = i_dec_valid && !busy_q;
  assign leave       = o_acc_valid && i_acc_ready;
  assign dec_write   = (i_dec_op == mem_sub_pkg::OP_WRITE);

  // RAM and APB are both launched on the taking edge
  data_ram u_data_ram (
    .clk         (clk),
    .i_rd_en     (take && i_dec_region == mem_sub_pkg::REGION_RAM && !dec_write),
    .i_wr_en     (take && i_dec_region == mem_sub_pkg::REGION_RAM && dec_write),
    .i_addr      (i_dec_addr[mem_sub_pkg::RAM_AW+1:2]),
    .i_wr_data   (i_dec_wdata),
    .o_rd_data   (ram_rd_data),
    .i_init_wen  (i_init_wen),
    .i_init_addr (i_init_addr),
    .i_init_data (i_init_data)
  );

  debug_apb_master u_debug_apb_master (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_start   (take && i_dec_region == mem_sub_pkg::REGION_DEBUG),
    .i_write   (dec_write),
    .i_addr    (i_dec_addr[mem_sub_pkg::APB_AW-1:0]),
    .i_wdata   (i_dec_wdata),
    .o_done    (apb_done),
    .o_rdata   (apb_rdata),
    .o_error   (apb_error),
    .o_paddr   (o_apb_paddr),
    .o_psel    (o_apb_psel),
    .o_penable (o_apb_penable),
    .o_pwrite  (o_apb_pwrite),
    .o_pwdata  (o_apb_pwdata),
    .i_pready  (i_apb_pready),
    .i_prdata  (i_apb_prdata),
    .i_pslverr (i_apb_pslverr)
  );

  // ==========================================================
  // Item control and tohost register
  // ==========================================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      busy_q      <= 1'b0;
      o_acc_valid <= 1'b0;
      o_tohost    <= '0;
    end
    else
    begin
      if (take)
        busy_q <= 1'b1;
      else if (leave)
        busy_q <= 1'b0;
      // Non-APB items finish one cycle after being taken
      if (leave)
        o_acc_valid <= 1'b0;
      else if (busy_q && !o_acc_valid &&
               (region_q != mem_sub_pkg::REGION_DEBUG || apb_done))
        o_acc_valid <= 1'b1;
      if (take && i_dec_region == mem_sub_pkg::REGION_TOHOST && dec_write)
        o_tohost <= i_dec_wdata;
    end
  end

  // Response payload, RAM read data comes straight from the RAM register
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      op_q     <= i_dec_op;
      region_q <= i_dec_region;
      rdata_q  <= (i_dec_region == mem_sub_pkg::REGION_TOHOST && !dec_write) ? o_tohost : '0;
      error_q  <= (i_dec_region == mem_sub_pkg::REGION_NONE);
    end
    else if (apb_done)
    begin
      rdata_q <= apb_rdata;
      error_q <= apb_error;
    end
  end

  assign o_acc_rdata = (region_q == mem_sub_pkg::REGION_RAM && op_q == mem_sub_pkg::OP_READ) ?
                       ram_rd_data : rdata_q;
  assign o_acc_error = error_q;

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
/* Data RAM of 4096 words with registered read, access write port and init port */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  wire                            clk,
  input  wire                            i_rd_en,
  input  wire                            i_wr_en,
  input  wire [mem_sub_pkg::RAM_AW-1:0]  i_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_wr_data,
  output logic [mem_sub_pkg::DATA_W-1:0] o_rd_data,
  input  wire                            i_init_wen,
  input  wire [mem_sub_pkg::ADDR_W-1:0]  i_init_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_init_data
);

  logic [mem_sub_pkg::DATA_W-1:0] mem [mem_sub_pkg::RAM_WORDS];
  logic                           init_hit;

  // Init bytes outside the 16 KB window are dropped
  assign init_hit = i_init_wen &&
                    (i_init_addr[mem_sub_pkg::ADDR_W-1:mem_sub_pkg::RAM_AW+2] == '0);

  // Init port wins when both hit the same word
  always_ff @(posedge clk)
  begin
    if (i_wr_en)
      mem[i_addr] <= i_wr_data;
    if (init_hit)
      mem[i_init_addr[mem_sub_pkg::RAM_AW+1:2]] <= i_init_data;
  end

  // Read data holds until the next read
  always_ff @(posedge clk)
  begin
    if (i_rd_en)
      o_rd_data <= mem[i_addr];
  end

endmodule

`default_nettype wire

// File: hdl/debug_apb_master.sv
/* APB master for single debug-area transfers, with setup and access phases */
`timescale 1ns/1ps
`default_nettype none

module debug_apb_master (
  input  wire                            clk,
  input  wire                            reset_n,
  input  wire                            i_start,
  input  wire                            i_write,
  input  wire [mem_sub_pkg::APB_AW-1:0]  i_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_wdata,
  output logic                           o_done,
  output logic [mem_sub_pkg::DATA_W-1:0] o_rdata,
  output logic                           o_error,
  output logic [mem_sub_pkg::APB_AW-1:0] o_paddr,
  output logic                           o_psel,
  output logic                           o_penable,
  output logic                           o_pwrite,
  output logic [mem_sub_pkg::DATA_W-1:0] o_pwdata,
  input  wire                            i_pready,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_prdata,
  input  wire                            i_pslverr
);

  mem_sub_pkg::apb_state_e state_q;

  // ==========================================================
  // Phase sequencing
  // ==========================================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q   <= mem_sub_pkg::APB_IDLE;
      o_psel    <= 1'b0;
      o_penable <= 1'b0;
      o_pwrite  <= 1'b0;
      o_done    <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;
      case (state_q)
        mem_sub_pkg::APB_IDLE:
          if (i_start)
          begin
            o_psel   <= 1'b1;
            o_pwrite <= i_write;
            state_q  <= mem_sub_pkg::APB_SETUP;
          end
        mem_sub_pkg::APB_SETUP:
        begin
          o_penable <= 1'b1;
          state_q   <= mem_sub_pkg::APB_ACCESS;
        end
        mem_sub_pkg::APB_ACCESS:
          // Slave may stretch the access phase
          if (i_pready)
          begin
            o_psel    <= 1'b0;
            o_penable <= 1'b0;
            o_done    <= 1'b1;
            state_q   <= mem_sub_pkg::APB_IDLE;
          end
        default:
        begin
          o_psel    <= 1'b0;
          o_penable <= 1'b0;
          state_q   <= mem_sub_pkg::APB_IDLE;
        end
      endcase
    end
  end

  // Address and write data latched once, read side captured on pready
  always_ff @(posedge clk)
  begin
    if (state_q == mem_sub_pkg::APB_IDLE && i_start)
    begin
      o_paddr  <= i_addr;
      o_pwdata <= i_wdata;
    end
    if (state_q == mem_sub_pkg::APB_ACCESS && i_pready)
    begin
      o_rdata <= i_prdata;
      o_error <= i_pslverr;
    end
  end

endmodule

`default_nettype wire

// File: hdl/mem_sub_pkg.sv
/* Address map, bus widths and the enum types shared by the request pipeline */
`default_nettype none

package mem_sub_pkg;

  // Request and data bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;

  // ==========================================================
  // Address map
  // ==========================================================
  // Data RAM, 16 KB at 0x0000_0000 to 0x0000_3FFF
  localparam int RAM_WORDS = 4096;
  localparam int RAM_AW    = 12;

  // Debug area, reached over APB while in debug mode
  localparam logic [ADDR_W-1:0] DEBUG_AREA_START = 32'h0001_0000;
  localparam logic [ADDR_W-1:0] DEBUG_AREA_END   = 32'h0001_1FFF;

  // APB carries the byte offset inside the debug area
  localparam int APB_AW = 13;

  localparam logic [ADDR_W-1:0] TOHOST_ADDR = 32'h8000_1000;

  // ==========================================================
  // Types
  // ==========================================================
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } op_e;

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_DEBUG,
    REGION_TOHOST,
    REGION_NONE
  } region_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

endpackage

`default_nettype wire

// File: hdl/mem_subsystem.sv
/* Memory subsystem top: decode, access and response stages in a row */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  wire                            clk,
  input  wire                            reset_n,
  // Request channel
  input  wire                            i_req_valid,
  output logic                           o_req_ready,
  input  wire mem_sub_pkg::op_e          i_req_op,
  input  wire [mem_sub_pkg::ADDR_W-1:0]  i_req_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_req_wdata,
  // Response channel
  output logic                           o_rsp_valid,
  input  wire                            i_rsp_ready,
  output logic [mem_sub_pkg::DATA_W-1:0] o_rsp_rdata,
  output logic                           o_rsp_error,
  // Control and RAM init
  input  wire                            i_debug_mode,
  input  wire                            i_init_wen,
  input  wire [mem_sub_pkg::ADDR_W-1:0]  i_init_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_init_data,
  output logic                           o_unavailable,
  output logic [mem_sub_pkg::DATA_W-1:0] o_tohost,
  // APB toward the debug area
  output logic [mem_sub_pkg::APB_AW-1:0] o_apb_paddr,
  output logic                           o_apb_psel,
  output logic                           o_apb_penable,
  output logic                           o_apb_pwrite,
  output logic [mem_sub_pkg::DATA_W-1:0] o_apb_pwdata,
  input  wire                            i_apb_pready,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_apb_prdata,
  input  wire                            i_apb_pslverr
);

  // Stage one to stage two
  logic                           dec_valid;
  logic                           dec_ready;
  mem_sub_pkg::op_e               dec_op;
  mem_sub_pkg::region_e           dec_region;
  logic [mem_sub_pkg::ADDR_W-1:0] dec_addr;
  logic [mem_sub_pkg::DATA_W-1:0] dec_wdata;

  // Stage two to stage three
  logic                           acc_valid;
  logic                           acc_ready;
  logic [mem_sub_pkg::DATA_W-1:0] acc_rdata;
  logic                           acc_error;

  req_decode u_req_decode (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_req_valid   (i_req_valid),
    .o_req_ready   (o_req_ready),
    .i_req_op      (i_req_op),
    .i_req_addr    (i_req_addr),
    .i_req_wdata   (i_req_wdata),
    .i_debug_mode  (i_debug_mode),
    .i_init_wen    (i_init_wen),
    .o_unavailable (o_unavailable),
    .o_dec_valid   (dec_valid),
    .i_dec_ready   (dec_ready),
    .o_dec_op      (dec_op),
    .o_dec_region  (dec_region),
    .o_dec_addr    (dec_addr),
    .o_dec_wdata   (dec_wdata)
  );

  access_stage u_access_stage (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_dec_valid   (dec_valid),
    .o_dec_ready   (dec_ready),
    .i_dec_op      (dec_op),
    .i_dec_region  (dec_region),
    .i_dec_addr    (dec_addr),
    .i_dec_wdata   (dec_wdata),
    .i_init_wen    (i_init_wen),
    .i_init_addr   (i_init_addr),
    .i_init_data   (i_init_data),
    .o_acc_valid   (acc_valid),
    .i_acc_ready   (acc_ready),
    .o_acc_rdata   (acc_rdata),
    .o_acc_error   (acc_error),
    .o_tohost      (o_tohost),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .i_apb_pslverr (i_apb_pslverr)
  );

  rsp_buffer u_rsp_buffer (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_acc_valid (acc_valid),
    .o_acc_ready (acc_ready),
    .i_acc_rdata (acc_rdata),
    .i_acc_error (acc_error),
    .o_rsp_valid (o_rsp_valid),
    .i_rsp_ready (i_rsp_ready),
    .o_rsp_rdata (o_rsp_rdata),
    .o_rsp_error (o_rsp_error)
  );

endmodule

`default_nettype wire

// File: hdl/req_decode.sv
/* Stage one: request intake, init window tracking and address classification */
`timescale 1ns/1ps
`default_nettype none

module req_decode (
  input  wire                            clk,
  input  wire                            reset_n,
  input  wire                            i_req_valid,
  output logic                           o_req_ready,
  input  wire mem_sub_pkg::op_e          i_req_op,
  input  wire [mem_sub_pkg::ADDR_W-1:0]  i_req_addr,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_req_wdata,
  input  wire                            i_debug_mode,
  input  wire                            i_init_wen,
  output logic                           o_unavailable,
  output logic                           o_dec_valid,
  input  wire                            i_dec_ready,
  output mem_sub_pkg::op_e               o_dec_op,
  output mem_sub_pkg::region_e           o_dec_region,
  output logic [mem_sub_pkg::ADDR_W-1:0] o_dec_addr,
  output logic [mem_sub_pkg::DATA_W-1:0] o_dec_wdata
);

  logic                 init_wen_q;
  logic                 init_active;
  logic                 req_fire;
  logic                 in_ram;
  logic                 in_debug;
  mem_sub_pkg::region_e region;

  // Init window follows the edges of i_init_wen
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      init_wen_q  <= 1'b0;
      init_active <= 1'b0;
    end
    else
    begin
      init_wen_q <= i_init_wen;
      if (i_init_wen && !init_wen_q)
        init_active <= 1'b1;
      else if (!i_init_wen && init_wen_q)
        init_active <= 1'b0;
    end
  end

  assign o_unavailable = init_active;

  // Closed from the first init write on, and while the stage register is stuck
  assign o_req_ready = !(init_active || i_init_wen) && (!o_dec_valid || i_dec_ready);
  assign req_fire    = i_req_valid && o_req_ready;

  // Region select
  always_comb
  begin
    in_ram   = (i_req_addr[mem_sub_pkg::ADDR_W-1:mem_sub_pkg::RAM_AW+2] == '0);
    in_debug = (i_req_addr >= mem_sub_pkg::DEBUG_AREA_START) &&
               (i_req_addr <= mem_sub_pkg::DEBUG_AREA_END);
    if (in_ram)
      region = mem_sub_pkg::REGION_RAM;
    else if (in_debug && i_debug_mode)
      region = mem_sub_pkg::REGION_DEBUG;
    else if (i_req_addr == mem_sub_pkg::TOHOST_ADDR)
      region = mem_sub_pkg::REGION_TOHOST;
    else
      region = mem_sub_pkg::REGION_NONE;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_dec_valid <= 1'b0;
    else if (req_fire)
      o_dec_valid <= 1'b1;
    else if (i_dec_ready)
      o_dec_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      o_dec_op     <= i_req_op;
      o_dec_region <= region;
      o_dec_addr   <= i_req_addr;
      o_dec_wdata  <= i_req_wdata;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rsp_buffer.sv
/* Stage three: one-entry response register facing the bus master */
`timescale 1ns/1ps
`default_nettype none

module rsp_buffer (
  input  wire                            clk,
  input  wire                            reset_n,
  input  wire                            i_acc_valid,
  output logic                           o_acc_ready,
  input  wire [mem_sub_pkg::DATA_W-1:0]  i_acc_rdata,
  input  wire                            i_acc_error,
  output logic                           o_rsp_valid,
  input  wire                            i_rsp_ready,
  output logic [mem_sub_pkg::DATA_W-1:0] o_rsp_rdata,
  output logic                           o_rsp_error
);

  logic load;

  // Refill in the same cycle the current response leaves
  assign o_acc_ready = !o_rsp_valid || i_rsp_ready;
  assign load        = i_acc_valid && o_acc_ready;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_rsp_valid <= 1'b0;
    else if (load)
      o_rsp_valid <= 1'b1;
    else if (i_rsp_ready)
      o_rsp_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      o_rsp_rdata <= i_acc_rdata;
      o_rsp_error <= i_acc_error;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_mem_subsystem \
  --Mdir "$BUILD_DIR" -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_mem_subsystem" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
  exit 1
fi
exit 0

// File: verification/mem_subsystem_chk.sv
/* Bound port assertions: init blocking, APB hold, stalled response hold, APB after reset */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_chk (
  input wire                            clk,
  input wire                            reset_n,
  input wire                            i_req_ready,
  input wire                            i_unavailable,
  input wire                            i_rsp_valid,
  input wire                            i_rsp_ready,
  input wire [mem_sub_pkg::DATA_W-1:0]  i_rsp_rdata,
  input wire                            i_rsp_error,
  input wire [mem_sub_pkg::APB_AW-1:0]  i_apb_paddr,
  input wire                            i_apb_psel,
  input wire                            i_apb_penable,
  input wire                            i_apb_pwrite,
  input wire [mem_sub_pkg::DATA_W-1:0]  i_apb_pwdata,
  input wire                            i_apb_pready
);

  // Requests stay blocked while the init window is open
  init_blocks_req: assert property (@(posedge clk) disable iff (!reset_n)
    i_unavailable |-> !i_req_ready)
    else $error("o_req_ready high inside the init window");

  // Setup and waited access cycles keep address and control
  apb_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (i_apb_psel && !(i_apb_penable && i_apb_pready)) |=>
    (i_apb_psel && $stable(i_apb_paddr) && $stable(i_apb_pwrite) && $stable(i_apb_pwdata)))
    else $error("APB address or control changed before pready");

  rsp_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (i_rsp_valid && !i_rsp_ready) |=>
    (i_rsp_valid && $stable(i_rsp_rdata) && $stable(i_rsp_error)))
    else $error("Stalled response changed or was dropped");

  apb_idle_in_reset: assert property (@(posedge clk)
    !reset_n |=> (!i_apb_psel && !i_apb_penable))
    else $error("APB select active right after reset");

endmodule

bind mem_subsystem mem_subsystem_chk u_mem_subsystem_chk (
  .clk           (clk),
  .reset_n       (reset_n),
  .i_req_ready   (o_req_ready),
  .i_unavailable (o_unavailable),
  .i_rsp_valid   (o_rsp_valid),
  .i_rsp_ready   (i_rsp_ready),
  .i_rsp_rdata   (o_rsp_rdata),
  .i_rsp_error   (o_rsp_error),
  .i_apb_paddr   (o_apb_paddr),
  .i_apb_psel    (o_apb_psel),
  .i_apb_penable (o_apb_penable),
  .i_apb_pwrite  (o_apb_pwrite),
  .i_apb_pwdata  (o_apb_pwdata),
  .i_apb_pready  (i_apb_pready)
);

`default_nettype wire

// File: verification/tb_mem_subsystem.sv
/* Memory subsystem testbench with clock, reset, APB slave model, directed tests and report */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

  localparam int WAIT_LIMIT = 200;
  localparam int BP_COUNT   = 64;

  logic                           clk = 1'b0;
  logic                           reset_n;
  logic                           req_valid;
  logic                           req_ready;
  mem_sub_pkg::op_e               req_op;
  logic [mem_sub_pkg::ADDR_W-1:0] req_addr;
  logic [mem_sub_pkg::DATA_W-1:0] req_wdata;
  logic                           rsp_valid;
  logic                           rsp_ready;
  logic [mem_sub_pkg::DATA_W-1:0] rsp_rdata;
  logic                           rsp_error;
  logic                           debug_mode;
  logic                           init_wen;
  logic [mem_sub_pkg::ADDR_W-1:0] init_addr;
  logic [mem_sub_pkg::DATA_W-1:0] init_data;
  logic                           unavailable;
  logic [mem_sub_pkg::DATA_W-1:0] tohost;
  logic [mem_sub_pkg::APB_AW-1:0] apb_paddr;
  logic                           apb_psel;
  logic                           apb_penable;
  logic                           apb_pwrite;
  logic [mem_sub_pkg::DATA_W-1:0] apb_pwdata;
  logic                           apb_pready  = 1'b0;
  logic [mem_sub_pkg::DATA_W-1:0] apb_prdata  = '0;
  logic                           apb_pslverr = 1'b0;

  // APB slave model state
  logic [31:0]                    apb_mem [16];
  logic [mem_sub_pkg::APB_AW-1:0] apb_last_paddr = '0;
  int                             access_cnt   = 0;
  int                             apb_sel_cnt  = 0;

  // Bench copy of the RAM words used under back-pressure
  logic [31:0] ram_model [16];
  logic [31:0] expected_q [$];

  integer seed;
  int     errors;
  int     timeouts;

  always #2 clk = ~clk;

  mem_subsystem u_mem_subsystem (
    .clk (clk), .reset_n (reset_n),
    .i_req_valid (req_valid), .o_req_ready (req_ready), .i_req_op (req_op),
    .i_req_addr (req_addr), .i_req_wdata (req_wdata),
    .o_rsp_valid (rsp_valid), .i_rsp_ready (rsp_ready),
    .o_rsp_rdata (rsp_rdata), .o_rsp_error (rsp_error),
    .i_debug_mode (debug_mode), .i_init_wen (init_wen), .i_init_addr (init_addr),
    .i_init_data (init_data), .o_unavailable (unavailable), .o_tohost (tohost),
    .o_apb_paddr (apb_paddr), .o_apb_psel (apb_psel), .o_apb_penable (apb_penable),
    .o_apb_pwrite (apb_pwrite), .o_apb_pwdata (apb_pwdata), .i_apb_pready (apb_pready),
    .i_apb_prdata (apb_prdata), .i_apb_pslverr (apb_pslverr)
  );

  // ==========================================================
  // APB slave model with pready in the second access cycle
  // ==========================================================
  always @(posedge clk)
  begin
    #1;
    if (apb_psel)
      apb_sel_cnt = apb_sel_cnt + 1;
    if (apb_psel && apb_penable && !apb_pready)
      access_cnt = access_cnt + 1;
    else
      access_cnt = 0;
    apb_pready  = (access_cnt == 2);
    apb_pslverr = apb_pready && apb_paddr[12];
    apb_prdata  = '0;
    if (apb_pready)
      apb_last_paddr = apb_paddr;
    if (apb_pready && !apb_paddr[12])
    begin
      if (apb_pwrite)
        apb_mem[apb_paddr[5:2]] = apb_pwdata;
      else
        apb_prdata = apb_mem[apb_paddr[5:2]];
    end
  end

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] init_pattern(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ ~addr ^ 32'h3C96_A55A;
  endfunction

  // Word idx of the block at byte 0x800
  function automatic logic [31:0] ram_addr(input logic [3:0] idx);
    return {20'h0, 1'b1, 5'b0, idx, 2'b00};
  endfunction

  task automatic send_request(input mem_sub_pkg::op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata);
    int   cnt;
    logic done;
    cnt       = 0;
    done      = 1'b0;
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    // Ready seen here holds until the next edge
    while (!done && cnt < WAIT_LIMIT)
    begin
      done = req_ready;
      next_cycle();
      cnt++;
    end
    req_valid = 1'b0;
    if (!done)
    begin
      timeouts++;
      $display("Timeout: request to 0x%08h was not accepted", addr);
    end
  endtask

  task automatic recv_response(output logic [31:0] rdata, output logic error);
    int cnt;
    cnt   = 0;
    rdata = '0;
    error = 1'b0;
    while (!rsp_valid && cnt < WAIT_LIMIT)
    begin
      next_cycle();
      cnt++;
    end
    if (!rsp_valid)
    begin
      timeouts++;
      $display("Timeout: no response arrived");
    end
    else
    begin
      rdata     = rsp_rdata;
      error     = rsp_error;
      rsp_ready = 1'b1;
      next_cycle();
      rsp_ready = 1'b0;
    end
  endtask

  task automatic transfer(input mem_sub_pkg::op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] exp_data,
                          input logic exp_error);
    logic [31:0] rdata;
    logic        error;
    send_request(op, addr, wdata);
    recv_response(rdata, error);
    check_word("o_rsp_rdata", rdata, exp_data);
    check_bit("o_rsp_error", error, exp_error);
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic init_load();
    logic [31:0] addr;
    for (int i = 0; i < 8; i++)
    begin
      addr      = 32'h0000_0200 + 32'(i * 4);
      init_wen  = 1'b1;
      init_addr = addr;
      init_data = init_pattern(addr);
      next_cycle();
      check_bit("o_unavailable", unavailable, 1'b1);
      check_bit("o_req_ready", req_ready, 1'b0);
    end
    init_wen = 1'b0;
    next_cycle();
    check_bit("o_unavailable", unavailable, 1'b0);
    check_bit("o_req_ready", req_ready, 1'b1);
    for (int i = 0; i < 8; i++)
    begin
      addr = 32'h0000_0200 + 32'(i * 4);
      transfer(mem_sub_pkg::OP_READ, addr, '0, init_pattern(addr), 1'b0);
    end
  endtask

  task automatic ram_write_read();
    transfer(mem_sub_pkg::OP_WRITE, 32'h0000_3FFC, 32'h1234_ABCD, '0, 1'b0);
    transfer(mem_sub_pkg::OP_WRITE, 32'h0000_0040, 32'hC0FF_EE01, '0, 1'b0);
    transfer(mem_sub_pkg::OP_READ, 32'h0000_3FFC, '0, 32'h1234_ABCD, 1'b0);
    transfer(mem_sub_pkg::OP_READ, 32'h0000_0040, '0, 32'hC0FF_EE01, 1'b0);
  endtask

  task automatic debug_area_access();
    debug_mode = 1'b1;
    transfer(mem_sub_pkg::OP_WRITE, mem_sub_pkg::DEBUG_AREA_START + 32'h8,
             32'h5EED_1234, '0, 1'b0);
    check_word("o_apb_paddr", 32'(apb_last_paddr), 32'h0000_0008);
    transfer(mem_sub_pkg::OP_READ, mem_sub_pkg::DEBUG_AREA_START + 32'h8,
             '0, 32'h5EED_1234, 1'b0);
    // Offset bit 12 makes the slave answer with pslverr
    transfer(mem_sub_pkg::OP_READ, mem_sub_pkg::DEBUG_AREA_START + 32'h1004, '0, '0, 1'b1);
    check_word("o_apb_paddr", 32'(apb_last_paddr), 32'h0000_1004);
  endtask

  task automatic debug_area_locked();
    int sel_before;
    debug_mode = 1'b0;
    sel_before = apb_sel_cnt;
    transfer(mem_sub_pkg::OP_READ, mem_sub_pkg::DEBUG_AREA_START + 32'h8, '0, '0, 1'b1);
    assert (apb_sel_cnt == sel_before)
    else
    begin
      $display("APB was selected for a debug access outside debug mode");
      errors++;
    end
  endtask

  task automatic tohost_and_unmapped();
    transfer(mem_sub_pkg::OP_WRITE, mem_sub_pkg::TOHOST_ADDR, 32'h0000_0001, '0, 1'b0);
    check_word("o_tohost", tohost, 32'h0000_0001);
    transfer(mem_sub_pkg::OP_READ, mem_sub_pkg::TOHOST_ADDR, '0, 32'h0000_0001, 1'b0);
    transfer(mem_sub_pkg::OP_READ, 32'h4000_0000, '0, '0, 1'b1);
    transfer(mem_sub_pkg::OP_WRITE, 32'h0000_4000, 32'hFFFF_FFFF, '0, 1'b1);
  endtask

  task automatic random_backpressure();
    logic [31:0] r;
    logic [31:0] rr;
    logic [31:0] wdata;
    logic [31:0] exp;
    logic [3:0]  idx;
    logic        got;
    int          cnt;
    for (int i = 0; i < 16; i++)
    begin
      wdata        = $random(seed);
      ram_model[i] = wdata;
      transfer(mem_sub_pkg::OP_WRITE, ram_addr(4'(i)), wdata, '0, 1'b0);
    end
    fork
      begin
        for (int i = 0; i < BP_COUNT; i++)
        begin
          r   = $random(seed);
          idx = r[3:0];
          if (r[4])
          begin
            ram_model[idx] = r ^ {r[15:0], r[31:16]};
            expected_q.push_back(32'h0);
            send_request(mem_sub_pkg::OP_WRITE, ram_addr(idx), ram_model[idx]);
          end
          else
          begin
            expected_q.push_back(ram_model[idx]);
            send_request(mem_sub_pkg::OP_READ, ram_addr(idx), '0);
          end
        end
      end
      begin
        for (int j = 0; j < BP_COUNT; j++)
        begin
          cnt = 0;
          got = 1'b0;
          while (!got && cnt < WAIT_LIMIT)
          begin
            rr        = $random(seed);
            rsp_ready = rr[0];
            if (rsp_valid && rsp_ready)
            begin
              got = 1'b1;
              exp = expected_q.pop_front();
              check_word("o_rsp_rdata", rsp_rdata, exp);
              check_bit("o_rsp_error", rsp_error, 1'b0);
            end
            next_cycle();
            cnt++;
          end
          if (!got)
          begin
            timeouts++;
            $display("Timeout: response %0d did not arrive under back-pressure", j);
          end
        end
        rsp_ready = 1'b0;
      end
    join
    assert (expected_q.size() == 0)
    else
    begin
      $display("Requests were left without a response");
      errors++;
    end
  endtask

  initial
  begin
    seed       = 36912;
    errors     = 0;
    timeouts   = 0;
    reset_n    = 1'b1;
    req_valid  = 1'b0;
    req_op     = mem_sub_pkg::OP_READ;
    req_addr   = '0;
    req_wdata  = '0;
    rsp_ready  = 1'b0;
    debug_mode = 1'b0;
    init_wen   = 1'b0;
    init_addr  = '0;
    init_data  = '0;
    #1;
    reset_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // Idle outputs out of reset
    check_bit("o_req_ready", req_ready, 1'b1);
    check_bit("o_rsp_valid", rsp_valid, 1'b0);
    check_bit("o_apb_psel", apb_psel, 1'b0);
    check_bit("o_apb_penable", apb_penable, 1'b0);
    check_bit("o_unavailable", unavailable, 1'b0);
    check_word("o_tohost", tohost, '0);

    init_load();
    ram_write_read();
    debug_area_access();
    debug_area_locked();
    tohost_and_unmapped();
    random_backpressure();

    $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
